//--- source/mem_pkg.sv
package mem_pkg;

    // datapath and register file widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // data memory geometry
    localparam int MEM_WORDS = 1024;
    localparam int MEM_IDX_W = 10;

    // address bit 30 steers the access to the I/O block
    localparam int IO_SEL_BIT = 30;

    // i/o register map, word offsets
    localparam int IO_OFS_W = 2;
    localparam logic [IO_OFS_W-1:0] IO_LED_OFS     = 2'd0;
    localparam logic [IO_OFS_W-1:0] IO_SCRATCH_OFS = 2'd1;
    localparam logic [IO_OFS_W-1:0] IO_ID_OFS      = 2'd2;
    localparam int LED_W = 8;
    localparam logic [XLEN-1:0] IO_ID_VALUE = 32'h5256_3349;

    // load/store kind, same encoding as funct3
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_op_e;

    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_BUSY = 2'd1,
        CTRL_DONE = 2'd2
    } ctrl_state_e;

    // instruction as delivered by execute
    typedef struct packed {
        logic [XLEN-1:0]       alu_result;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       store_data;
        ls_op_e                ls_op;
        logic                  mem_read;
        logic                  mem_write;
    } exe_req_t;

    typedef struct packed {
        logic            read;
        logic            write;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        ls_op_e          ls_op;
    } mem_req_t;

    typedef struct packed {
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic                  mem_read;
        logic                  io_sel;
        ls_op_e                ls_op;
        logic [1:0]            addr_lo;
        logic [XLEN-1:0]       rdata;
    } mem_wb_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } rf_write_t;

endpackage

//--- source/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
    input  logic read_i,
    input  logic write_i,
    input  logic addr_bit_i,
    output logic dmem_rd_o,
    output logic dmem_wr_o,
    output logic io_sel_o
);

    logic access;

    assign access = read_i || write_i;

    // only a real access is marked as I/O
    assign io_sel_o = access && addr_bit_i;

    // data memory never sees an I/O address
    assign dmem_rd_o = read_i && !addr_bit_i;
    assign dmem_wr_o = write_i && !addr_bit_i;

endmodule

//--- source/data_mem_ctrl.sv
`timescale 1ns/1ps

module data_mem_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  mem_pkg::mem_req_t        req_i,
    output logic                     ready_o,
    output logic [mem_pkg::XLEN-1:0] rdata_o
);

    mem_pkg::ctrl_state_e state_q;
    mem_pkg::ctrl_state_e state_d;

    logic [mem_pkg::XLEN-1:0]      mem_q [mem_pkg::MEM_WORDS];
    logic [mem_pkg::XLEN-1:0]      rdata_q;
    logic [mem_pkg::MEM_IDX_W-1:0] idx;
    logic [3:0]                    byte_en;
    logic [mem_pkg::XLEN-1:0]      wdata_lanes;
    logic                          access;

    assign access = req_i.read || req_i.write;
    assign idx    = req_i.addr[mem_pkg::MEM_IDX_W+1:2];

    // memory starts out cleared
    initial begin
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // idle -> busy -> done for every access
    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::CTRL_IDLE: begin
                if (access) begin
                    state_d = mem_pkg::CTRL_BUSY;
                end
            end
            mem_pkg::CTRL_BUSY: begin
                state_d = mem_pkg::CTRL_DONE;
            end
            default: begin
                state_d = mem_pkg::CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= mem_pkg::CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // lane enables and replicated store data
    always_comb begin
        case (req_i.ls_op)
            mem_pkg::LS_B, mem_pkg::LS_BU: begin
                byte_en     = 4'b0001 << req_i.addr[1:0];
                wdata_lanes = {4{req_i.wdata[7:0]}};
            end
            mem_pkg::LS_H, mem_pkg::LS_HU: begin
                byte_en     = 4'b0011 << {req_i.addr[1], 1'b0};
                wdata_lanes = {2{req_i.wdata[15:0]}};
            end
            default: begin
                byte_en     = 4'b1111;
                wdata_lanes = req_i.wdata;
            end
        endcase
    end

    // word fetched while busy, store lands at the end of done
    always @(posedge clk_i) begin
        if (state_q == mem_pkg::CTRL_BUSY) begin
            rdata_q <= mem_q[idx];
        end
        if (state_q == mem_pkg::CTRL_DONE && req_i.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    mem_q[idx][8*lane +: 8] <= wdata_lanes[8*lane +: 8];
                end
            end
        end
    end

    assign ready_o = (state_q == mem_pkg::CTRL_DONE);
    assign rdata_o = rdata_q;

endmodule

//--- source/io_unit.sv
`timescale 1ns/1ps

module io_unit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  mem_pkg::mem_req_t         req_i,
    output logic                      busy_o,
    output logic [mem_pkg::XLEN-1:0]  rdata_o,
    output logic [mem_pkg::LED_W-1:0] led_o
);

    logic                         phase_q;
    logic                         access;
    logic [mem_pkg::IO_OFS_W-1:0] ofs;
    logic [mem_pkg::LED_W-1:0]    led_q;
    logic [mem_pkg::XLEN-1:0]     scratch_q;
    logic [mem_pkg::XLEN-1:0]     rdata_q;
    logic [mem_pkg::XLEN-1:0]     read_word;

    assign access = req_i.read || req_i.write;
    assign ofs    = req_i.addr[mem_pkg::IO_OFS_W+1:2];

    // first cycle of an access is busy
    assign busy_o = access && !phase_q;

    always_comb begin
        case (ofs)
            mem_pkg::IO_LED_OFS: begin
                read_word = {{(mem_pkg::XLEN - mem_pkg::LED_W){1'b0}}, led_q};
            end
            mem_pkg::IO_SCRATCH_OFS: begin
                read_word = scratch_q;
            end
            mem_pkg::IO_ID_OFS: begin
                read_word = mem_pkg::IO_ID_VALUE;
            end
            default: begin
                read_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            phase_q   <= 1'b0;
            led_q     <= '0;
            scratch_q <= '0;
        end else begin
            phase_q <= access && !phase_q;
            // id register is read only
            if (phase_q && req_i.write) begin
                if (ofs == mem_pkg::IO_LED_OFS) begin
                    led_q <= req_i.wdata[mem_pkg::LED_W-1:0];
                end
                if (ofs == mem_pkg::IO_SCRATCH_OFS) begin
                    scratch_q <= req_i.wdata;
                end
            end
        end
    end

    // read value held until the next read completes
    always_ff @(posedge clk_i) begin
        if (phase_q && req_i.read) begin
            rdata_q <= read_word;
        end
    end

    assign rdata_o = rdata_q;
    assign led_o   = led_q;

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  mem_pkg::exe_req_t        exe_req_i,
    input  logic                     dmem_ready_i,
    input  logic [mem_pkg::XLEN-1:0] dmem_rdata_i,
    input  logic                     io_busy_i,
    input  logic [mem_pkg::XLEN-1:0] io_rdata_i,
    output mem_pkg::mem_req_t        dmem_req_o,
    output mem_pkg::mem_req_t        io_req_o,
    output logic                     stall_o,
    output mem_pkg::mem_wb_t         wb_o
);

    logic             dmem_rd;
    logic             dmem_wr;
    logic             io_sel;
    mem_pkg::mem_wb_t wb_q;

    addr_decoder u_addr_decoder (
        .read_i     (exe_req_i.mem_read),
        .write_i    (exe_req_i.mem_write),
        .addr_bit_i (exe_req_i.addr[mem_pkg::IO_SEL_BIT]),
        .dmem_rd_o  (dmem_rd),
        .dmem_wr_o  (dmem_wr),
        .io_sel_o   (io_sel)
    );

    // data memory request
    always_comb begin
        dmem_req_o.read  = dmem_rd;
        dmem_req_o.write = dmem_wr;
        dmem_req_o.addr  = exe_req_i.addr;
        dmem_req_o.wdata = exe_req_i.store_data;
        dmem_req_o.ls_op = exe_req_i.ls_op;
    end

    // i/o request
    always_comb begin
        io_req_o.read  = exe_req_i.mem_read && io_sel;
        io_req_o.write = exe_req_i.mem_write && io_sel;
        io_req_o.addr  = exe_req_i.addr;
        io_req_o.wdata = exe_req_i.store_data;
        io_req_o.ls_op = exe_req_i.ls_op;
    end

    // hold execute while either target is still working
    assign stall_o = ((dmem_rd || dmem_wr) && !dmem_ready_i) || io_busy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_q.reg_we   <= 1'b0;
            wb_q.mem_read <= 1'b0;
        end else if (stall_o) begin
            // bubble toward write-back
            wb_q.reg_we   <= 1'b0;
            wb_q.mem_read <= 1'b0;
        end else begin
            wb_q.reg_we     <= exe_req_i.reg_we;
            wb_q.rd         <= exe_req_i.rd;
            wb_q.alu_result <= exe_req_i.alu_result;
            wb_q.mem_read   <= exe_req_i.mem_read;
            wb_q.io_sel     <= io_sel;
            wb_q.ls_op      <= exe_req_i.ls_op;
            wb_q.addr_lo    <= exe_req_i.addr[1:0];
            wb_q.rdata      <= io_sel ? io_rdata_i : dmem_rdata_i;
        end
    end

    assign wb_o = wb_q;

endmodule

//--- source/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  mem_pkg::mem_wb_t         wb_i,
    input  logic [mem_pkg::XLEN-1:0] io_rdata_i,
    output mem_pkg::rf_write_t       rf_write_o
);

    logic [mem_pkg::XLEN-1:0] load_word;
    logic [mem_pkg::XLEN-1:0] shifted;
    logic [mem_pkg::XLEN-1:0] load_val;
    logic [mem_pkg::XLEN-1:0] result;
    mem_pkg::rf_write_t       rf_q;

    // i/o read data is registered on the same edge as the stage register
    assign load_word = wb_i.io_sel ? io_rdata_i : wb_i.rdata;
    assign shifted   = load_word >> {wb_i.addr_lo, 3'b000};

    always_comb begin
        case (wb_i.ls_op)
            mem_pkg::LS_B:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            mem_pkg::LS_H:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            mem_pkg::LS_BU: load_val = {24'd0, shifted[7:0]};
            mem_pkg::LS_HU: load_val = {16'd0, shifted[15:0]};
            default:        load_val = load_word;
        endcase
    end

    assign result = wb_i.mem_read ? load_val : wb_i.alu_result;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rf_q.we <= 1'b0;
        end else begin
            rf_q.we   <= wb_i.reg_we;
            rf_q.rd   <= wb_i.rd;
            rf_q.data <= result;
        end
    end

    assign rf_write_o = rf_q;

endmodule

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  mem_pkg::exe_req_t         exe_req_i,
    output logic                      stall_o,
    output mem_pkg::rf_write_t        rf_write_o,
    output logic [mem_pkg::LED_W-1:0] led_o
);

    mem_pkg::mem_req_t        dmem_req;
    mem_pkg::mem_req_t        io_req;
    logic                     dmem_ready;
    logic [mem_pkg::XLEN-1:0] dmem_rdata;
    logic                     io_busy;
    logic [mem_pkg::XLEN-1:0] io_rdata;
    mem_pkg::mem_wb_t         wb;

    mem_stage u_mem_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .exe_req_i    (exe_req_i),
        .dmem_ready_i (dmem_ready),
        .dmem_rdata_i (dmem_rdata),
        .io_busy_i    (io_busy),
        .io_rdata_i   (io_rdata),
        .dmem_req_o   (dmem_req),
        .io_req_o     (io_req),
        .stall_o      (stall_o),
        .wb_o         (wb)
    );

    data_mem_ctrl u_data_mem_ctrl (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (dmem_req),
        .ready_o (dmem_ready),
        .rdata_o (dmem_rdata)
    );

    io_unit u_io_unit (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (io_req),
        .busy_o  (io_busy),
        .rdata_o (io_rdata),
        .led_o   (led_o)
    );

    writeback_stage u_writeback_stage (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_i       (wb),
        .io_rdata_i (io_rdata),
        .rf_write_o (rf_write_o)
    );

endmodule

//--- test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// shadow data memory and i/o registers
logic [31:0]               shadow_mem [mem_pkg::MEM_WORDS];
logic [mem_pkg::LED_W-1:0] shadow_led;
logic [31:0]               shadow_scratch;

// whole word at an address, data memory or i/o
function automatic logic [31:0] model_word(input logic [31:0] addr);
    if (!addr[mem_pkg::IO_SEL_BIT]) return shadow_mem[addr[mem_pkg::MEM_IDX_W+1:2]];
    case (addr[3:2])
        mem_pkg::IO_LED_OFS:     return 32'(shadow_led);
        mem_pkg::IO_SCRATCH_OFS: return shadow_scratch;
        mem_pkg::IO_ID_OFS:      return mem_pkg::IO_ID_VALUE;
        default:                 return '0;
    endcase
endfunction

// picks the addressed lane and extends it by the load kind
function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_pkg::ls_op_e op);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    word = model_word(addr);
    b = word[8*addr[1:0] +: 8];
    h = word[16*addr[1] +: 16];
    case (op)
        mem_pkg::LS_B:  return {{24{b[7]}}, b};
        mem_pkg::LS_BU: return {24'h0, b};
        mem_pkg::LS_H:  return {{16{h[15]}}, h};
        mem_pkg::LS_HU: return {16'h0, h};
        default:        return word;
    endcase
endfunction

function automatic void model_store(input logic [31:0] addr, input logic [31:0] data,
                                    input mem_pkg::ls_op_e op);
    logic [mem_pkg::MEM_IDX_W-1:0] idx;
    idx = addr[mem_pkg::MEM_IDX_W+1:2];
    if (addr[mem_pkg::IO_SEL_BIT]) begin
        // i/o stores take the whole word, id stays constant
        if (addr[3:2] == mem_pkg::IO_LED_OFS) shadow_led = data[mem_pkg::LED_W-1:0];
        if (addr[3:2] == mem_pkg::IO_SCRATCH_OFS) shadow_scratch = data;
    end else if (op == mem_pkg::LS_B || op == mem_pkg::LS_BU) begin
        shadow_mem[idx][8*addr[1:0] +: 8] = data[7:0];
    end else if (op == mem_pkg::LS_H || op == mem_pkg::LS_HU) begin
        shadow_mem[idx][16*addr[1] +: 16] = data[15:0];
    end else begin
        shadow_mem[idx] = data;
    end
endfunction

`endif

//--- test/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int N_ALU   = 4;
    localparam int N_WORD  = 4;
    localparam int N_STEER = 3;
    // reset loads, sub-word block of 25 and i/o block of 7
    localparam int N_TESTS = 2 + N_ALU + 2 * N_WORD + 25 + 7 + 3 * N_STEER;
    localparam logic [31:0] IO_BASE     = 32'h1 << mem_pkg::IO_SEL_BIT;
    localparam logic [31:0] LED_ADDR    = IO_BASE + 4 * mem_pkg::IO_LED_OFS;
    localparam logic [31:0] SCRATCH_ADDR = IO_BASE + 4 * mem_pkg::IO_SCRATCH_OFS;
    localparam logic [31:0] ID_ADDR     = IO_BASE + 4 * mem_pkg::IO_ID_OFS;

    logic               clk_i;
    logic               rst_i;
    mem_pkg::exe_req_t  exe_req;
    logic               stall;
    mem_pkg::rf_write_t rf_write;
    logic [7:0]         led;
    integer             seed;
    int                 errors;
    logic [31:0]        addr;
    logic [31:0]        data;

    `include "tb_ref_model.svh"

    mem_subsys_top DUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .exe_req_i  (exe_req),
        .stall_o    (stall),
        .rf_write_o (rf_write),
        .led_o      (led)
    );

    always #50 clk_i = ~clk_i;

    task automatic stop_run(input string line);
        errors++;
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else stop_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    assert property (@(posedge clk_i) !rst_i |-> !stall)
    else stop_run("stall_o went high while reset was held");

    assert property (@(posedge clk_i) !(exe_req.mem_read || exe_req.mem_write) |-> !stall)
    else stop_run("stall_o went high with no memory access presented");

    // hold through the stall, then expect the write port two edges after capture
    task automatic run_instr(input mem_pkg::exe_req_t req, input logic [31:0] exp_data);
        int   stalls;
        int   exp_stalls;
        logic st;
        stalls = 0;
        exp_stalls = 0;
        if (req.mem_read || req.mem_write) exp_stalls = req.addr[mem_pkg::IO_SEL_BIT] ? 1 : 2;
        exe_req = req;
        do begin
            @(posedge clk_i);
            st = stall;
            if (st) stalls++;
        end while (st);
        @(negedge clk_i);
        exe_req = '0;
        check_eq("stall_o cycles", stalls, exp_stalls);
        check_eq("rf_write_o.we", rf_write.we, 1'b0);
        @(negedge clk_i);
        check_eq("rf_write_o.we", rf_write.we, req.reg_we);
        if (req.reg_we) begin
            check_eq("rf_write_o.rd", rf_write.rd, req.rd);
            check_eq("rf_write_o.data", rf_write.data, exp_data);
        end
    endtask

    // a store when wr is set, otherwise a load into rd
    task automatic do_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                             input mem_pkg::ls_op_e op);
        mem_pkg::exe_req_t req;
        req = '0;
        req.mem_write = wr;
        req.mem_read = !wr;
        req.reg_we = !wr;
        req.rd = a[6:2];
        req.addr = a;
        req.store_data = d;
        req.ls_op = op;
        run_instr(req, model_load(a, op));
        if (wr) model_store(a, d, op);
    endtask

    function automatic logic [31:0] random_dmem_addr();
        logic [31:0]                   rnd;
        logic [mem_pkg::MEM_IDX_W-1:0] idx;
        rnd = $random(seed);
        idx = rnd[mem_pkg::MEM_IDX_W-1:0];
        return 32'(idx) << 2;
    endfunction

    initial begin
        mem_pkg::exe_req_t alu;
        seed = 32'h852f_fdaa;
        errors = 0;
        clk_i = 1'b0;
        rst_i = 1'b0;
        exe_req = '0;
        foreach (shadow_mem[i]) shadow_mem[i] = '0;
        shadow_led = '0;
        shadow_scratch = '0;
        repeat (5) begin
            @(negedge clk_i);
            check_eq("stall_o", stall, 1'b0);
            check_eq("rf_write_o.we", rf_write.we, 1'b0);
            check_eq("led_o", led, '0);
        end
        rst_i = 1'b1;
        // memory reads as zero after reset
        do_access(1'b0, random_dmem_addr(), '0, mem_pkg::LS_W);
        do_access(1'b0, random_dmem_addr(), '0, mem_pkg::LS_W);
        for (int i = 0; i < N_ALU; i++) begin
            alu = '0;
            alu.reg_we = 1'b1;
            alu.rd = 5'($random(seed));
            alu.alu_result = $random(seed);
            run_instr(alu, alu.alu_result);
        end
        for (int i = 0; i < N_WORD; i++) begin
            addr = random_dmem_addr();
            do_access(1'b1, addr, $random(seed), mem_pkg::LS_W);
            do_access(1'b0, addr, '0, mem_pkg::LS_W);
        end
        addr = random_dmem_addr();
        do_access(1'b1, addr, $random(seed), mem_pkg::LS_W);
        for (int ofs = 0; ofs < 4; ofs++) begin
            // alternate the sign bit so both extensions show up
            data = $random(seed);
            data[7] = (ofs % 2 == 1);
            do_access(1'b1, addr + ofs, data, mem_pkg::LS_B);
            do_access(1'b0, addr + ofs, '0, mem_pkg::LS_B);
            do_access(1'b0, addr + ofs, '0, mem_pkg::LS_BU);
            do_access(1'b0, addr, '0, mem_pkg::LS_W);
        end
        for (int ofs = 0; ofs < 4; ofs += 2) begin
            data = $random(seed);
            data[15] = (ofs == 0);
            do_access(1'b1, addr + ofs, data, mem_pkg::LS_H);
            do_access(1'b0, addr + ofs, '0, mem_pkg::LS_H);
            do_access(1'b0, addr + ofs, '0, mem_pkg::LS_HU);
            do_access(1'b0, addr, '0, mem_pkg::LS_W);
        end
        data = $random(seed);
        do_access(1'b1, LED_ADDR, data, mem_pkg::LS_W);
        check_eq("led_o", led, data[7:0]);
        do_access(1'b0, LED_ADDR, '0, mem_pkg::LS_W);
        do_access(1'b1, SCRATCH_ADDR, $random(seed), mem_pkg::LS_W);
        do_access(1'b0, SCRATCH_ADDR, '0, mem_pkg::LS_W);
        do_access(1'b0, ID_ADDR, '0, mem_pkg::LS_W);
        do_access(1'b1, ID_ADDR, $random(seed), mem_pkg::LS_W);
        do_access(1'b0, ID_ADDR, '0, mem_pkg::LS_W);
        // i/o store must leave the aliased memory word alone
        for (int i = 0; i < N_STEER; i++) begin
            addr = random_dmem_addr();
            data = $random(seed);
            do_access(1'b1, addr, data, mem_pkg::LS_W);
            do_access(1'b1, addr | IO_BASE, ~data, mem_pkg::LS_W);
            do_access(1'b0, addr, '0, mem_pkg::LS_W);
        end
        check_eq("led_o", led, shadow_led);
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_run("one or more checks failed");
        end
    end

    // at most six cycles per instruction, plus reset
    initial begin
        repeat (N_TESTS * 6 + 20) @(posedge clk_i);
        stop_run("timeout: the run did not reach its end in time");
    end

endmodule

//--- flist.f
+incdir+test
source/mem_pkg.sv
source/addr_decoder.sv
source/data_mem_ctrl.sv
source/io_unit.sv
source/mem_stage.sv
source/writeback_stage.sv
source/mem_subsys_top.sv
test/tb_mem_subsys.sv
